// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing --assert
SIM_FLAGS   = --binary --timing --assert
TOP         = uart_echo_tb
FILELIST    = uart_echo.f
BUILD_DIR   = obj_dir
PASS_MSG    = TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the pass line shows up in the simulation output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: hdl/echo_line_buffer.sv
// line buffer for the echo path
// collects bytes until the line goes quiet, then replays
// the line wrapped in marker bytes to the transmitter
`timescale 1ns/10ps

module echo_line_buffer (
	input  logic                           sys_clk,
	input  logic                           sys_rst_n,
	input  logic [uart_pkg::DATA_BITS-1:0] rx_data,
	input  logic                           rx_valid,
	output logic [uart_pkg::DATA_BITS-1:0] tx_data,
	output logic                           tx_valid,
	input  logic                           tx_ready,
	output logic [echo_pkg::LEN_WIDTH-1:0] line_len,
	output logic                           echo_busy
);

	typedef enum logic [1:0] {
		ST_COLLECT,	// empty, waiting for a first byte
		ST_WAIT_GAP,	// bytes stored, counting idle clocks
		ST_DRAIN
	} buf_state_t;

	buf_state_t state;

	logic [uart_pkg::DATA_BITS-1:0] line_mem [echo_pkg::LINE_DEPTH];
	logic [echo_pkg::PTR_WIDTH-1:0] wr_ptr;	// next payload slot
	logic [echo_pkg::PTR_WIDTH-1:0] rd_ptr;
	logic [echo_pkg::PTR_WIDTH-1:0] last_ptr;
	logic [echo_pkg::GAP_CNT_W-1:0] gap_cnt;

	logic accept;	// byte arrived while not draining
	logic store;
	logic gap_done;
	logic tx_fire;

	assign accept = rx_valid && (state != ST_DRAIN);
	assign store = accept && (wr_ptr != echo_pkg::PAYLOAD_LIMIT);
	// a byte on the final gap cycle restarts the count instead
	assign gap_done = (state == ST_WAIT_GAP) && !rx_valid &&
		(gap_cnt == echo_pkg::GAP_END_CNT);
	assign tx_fire = tx_valid && tx_ready;

	// trailing markers sit right after the payload
	assign last_ptr = wr_ptr + echo_pkg::PTR_WIDTH'(echo_pkg::MARK_COUNT - 1);

	assign tx_valid = (state == ST_DRAIN);
	assign tx_data = line_mem[rd_ptr];
	assign echo_busy = (state == ST_DRAIN);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= ST_COLLECT;
			wr_ptr <= echo_pkg::PAYLOAD_BASE;
			rd_ptr <= '0;
			gap_cnt <= '0;
			line_len <= '0;
		end else begin
			case (state)
				ST_COLLECT: begin
					gap_cnt <= '0;
					if (store) begin
						wr_ptr <= wr_ptr + 1'b1;
						state <= ST_WAIT_GAP;
					end
				end
				ST_WAIT_GAP: begin
					if (accept) begin
						gap_cnt <= '0;	// line still active, even when full
						if (store)
							wr_ptr <= wr_ptr + 1'b1;
					end else if (gap_done) begin
						gap_cnt <= '0;
						rd_ptr <= '0;
						line_len <= echo_pkg::LEN_WIDTH'(wr_ptr - echo_pkg::PAYLOAD_BASE);
						state <= ST_DRAIN;
					end else
						gap_cnt <= gap_cnt + 1'b1;
				end
				ST_DRAIN: begin
					if (tx_fire) begin
						if (rd_ptr == last_ptr) begin
							wr_ptr <= echo_pkg::PAYLOAD_BASE;	// empty for next line
							state <= ST_COLLECT;
						end else
							rd_ptr <= rd_ptr + 1'b1;
					end
				end
				default: state <= ST_COLLECT;
			endcase
		end
	end

	// storage array
	// leading and trailing markers are written as the line closes
	always_ff @(posedge sys_clk) begin
		if (store)
			line_mem[wr_ptr] <= rx_data;
		else if (gap_done) begin
			for (int i = 0; i < echo_pkg::MARK_COUNT; i++) begin
				line_mem[i] <= echo_pkg::FRAME_MARK;
				line_mem[wr_ptr + echo_pkg::PTR_WIDTH'(i)] <= echo_pkg::FRAME_MARK;
			end
		end
	end

endmodule

// File: hdl/echo_pkg.sv
// line framing and buffer sizes for the echo path
package echo_pkg;

	localparam logic [uart_pkg::DATA_BITS-1:0] FRAME_MARK = 8'h26;	// "&"
	localparam int MARK_COUNT = 2;	// markers on each side
	localparam int LINE_DEPTH = 64;
	localparam int MAX_PAYLOAD = LINE_DEPTH - 2 * MARK_COUNT;	// 60
	// two character times of silence ends a line
	localparam int IDLE_GAP_CLKS = 2 * uart_pkg::FRAME_BITS * uart_pkg::CLKS_PER_BIT;
	localparam int LEN_WIDTH = 8;

	localparam int PTR_WIDTH = $clog2(LINE_DEPTH);
	localparam int GAP_CNT_W = $clog2(IDLE_GAP_CLKS);

	localparam logic [PTR_WIDTH-1:0] PAYLOAD_BASE = PTR_WIDTH'(MARK_COUNT);
	localparam logic [PTR_WIDTH-1:0] PAYLOAD_LIMIT = PTR_WIDTH'(MARK_COUNT + MAX_PAYLOAD);
	localparam logic [GAP_CNT_W-1:0] GAP_END_CNT = GAP_CNT_W'(IDLE_GAP_CLKS - 1);

endpackage

// File: hdl/uart_echo_top.sv
// uart line echo top level
// receiver -> line buffer -> transmitter
`timescale 1ns/10ps

module uart_echo_top (
	input  logic                           sys_clk,
	input  logic                           sys_rst_n,
	input  logic                           uart_rx_line,
	output logic                           uart_tx_line,
	output logic [echo_pkg::LEN_WIDTH-1:0] line_len,
	output logic                           echo_busy
);

	logic [uart_pkg::DATA_BITS-1:0] rx_data;
	logic                           rx_valid;	// no back-pressure on this link
	logic [uart_pkg::DATA_BITS-1:0] tx_data;
	logic                           tx_valid;
	logic                           tx_ready;

	uart_rx ins_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_line   (uart_rx_line),
		.rx_data   (rx_data),
		.rx_valid  (rx_valid)
	);

	echo_line_buffer ins_line_buffer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_data   (rx_data),
		.rx_valid  (rx_valid),
		.tx_data   (tx_data),
		.tx_valid  (tx_valid),
		.tx_ready  (tx_ready),
		.line_len  (line_len),
		.echo_busy (echo_busy)
	);

	uart_tx ins_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_data   (tx_data),
		.tx_valid  (tx_valid),
		.tx_ready  (tx_ready),
		.tx_line   (uart_tx_line)
	);

endmodule

// File: hdl/uart_pkg.sv
// serial line timing shared by receiver, transmitter and testbench
// 8N1 framing, each bit timed by a clock counter
package uart_pkg;

	localparam int CLK_FREQ_HZ = 10_000_000;	// 100 ns system clock
	localparam int BAUD_RATE = 625_000;
	localparam int CLKS_PER_BIT = CLK_FREQ_HZ / BAUD_RATE;	// 16
	localparam int DATA_BITS = 8;
	localparam int STOP_BITS = 1;
	localparam int FRAME_BITS = 1 + DATA_BITS + STOP_BITS;	// start + data + stop

	localparam int CLK_CNT_W = $clog2(CLKS_PER_BIT);
	localparam int BIT_CNT_W = $clog2(DATA_BITS);
	localparam int FRAME_CNT_W = $clog2(FRAME_BITS);

	// counter end values, sized to their counters
	localparam logic [CLK_CNT_W-1:0] BIT_END_CNT = CLK_CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CLK_CNT_W-1:0] HALF_BIT_CNT = CLK_CNT_W'(CLKS_PER_BIT / 2 - 1);
	localparam logic [BIT_CNT_W-1:0] LAST_DATA_BIT = BIT_CNT_W'(DATA_BITS - 1);
	localparam logic [FRAME_CNT_W-1:0] LAST_FRAME_BIT = FRAME_CNT_W'(FRAME_BITS - 1);

endpackage

// File: hdl/uart_rx.sv
// serial receiver, 8N1
// two-flop synchronizer, start edge detect, mid-bit sampling
// bytes with a low stop bit are dropped
`timescale 1ns/10ps

module uart_rx (
	input  logic                           sys_clk,
	input  logic                           sys_rst_n,
	input  logic                           rx_line,
	output logic [uart_pkg::DATA_BITS-1:0] rx_data,
	output logic                           rx_valid
);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t state;

	logic rx_meta;
	logic rx_sync;
	logic rx_sync_d;	// previous synced level for edge detect
	logic start_edge;
	logic bit_end;
	logic [uart_pkg::CLK_CNT_W-1:0] clk_cnt;
	logic [uart_pkg::BIT_CNT_W-1:0] bit_cnt;
	logic [uart_pkg::DATA_BITS-1:0] shift_reg;

	assign start_edge = rx_sync_d && !rx_sync;
	assign bit_end = (clk_cnt == uart_pkg::BIT_END_CNT);

	// line idles high
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_sync_d <= 1'b1;
		end else begin
			rx_meta <= rx_line;
			rx_sync <= rx_meta;
			rx_sync_d <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= RX_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;	// single cycle pulse
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					if (start_edge)
						state <= RX_START;
				end
				RX_START: begin
					// recheck at middle of start bit, glitches go back to idle
					if (clk_cnt == uart_pkg::HALF_BIT_CNT) begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						state <= rx_sync ? RX_IDLE : RX_DATA;
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				RX_DATA: begin
					if (bit_end) begin
						clk_cnt <= '0;
						if (bit_cnt == uart_pkg::LAST_DATA_BIT)
							state <= RX_STOP;
						else
							bit_cnt <= bit_cnt + 1'b1;
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				RX_STOP: begin
					if (bit_end) begin
						state <= RX_IDLE;
						rx_valid <= rx_sync;	// framing check
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// lsb arrives first, shift in from the top
	always_ff @(posedge sys_clk) begin
		if (state == RX_DATA && bit_end)
			shift_reg <= {rx_sync, shift_reg[uart_pkg::DATA_BITS-1:1]};
		if (state == RX_STOP && bit_end && rx_sync)
			rx_data <= shift_reg;
	end

endmodule

// File: hdl/uart_tx.sv
// serial transmitter, 8N1
// ready/valid byte input, lsb first on the line
`timescale 1ns/10ps

module uart_tx (
	input  logic                           sys_clk,
	input  logic                           sys_rst_n,
	input  logic [uart_pkg::DATA_BITS-1:0] tx_data,
	input  logic                           tx_valid,
	output logic                           tx_ready,
	output logic                           tx_line
);

	logic busy;
	logic load;
	logic bit_end;
	logic [uart_pkg::CLK_CNT_W-1:0] clk_cnt;
	logic [uart_pkg::FRAME_CNT_W-1:0] bit_idx;	// 0 is the start bit
	logic [uart_pkg::FRAME_BITS-2:0] shift_reg;	// data then stop bits

	assign tx_ready = !busy;
	assign load = tx_valid && tx_ready;
	assign bit_end = busy && (clk_cnt == uart_pkg::BIT_END_CNT);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
			tx_line <= 1'b1;	// idle high
		end else if (load) begin
			busy <= 1'b1;
			clk_cnt <= '0;
			bit_idx <= '0;
			tx_line <= 1'b0;	// start bit
		end else if (busy) begin
			if (bit_end) begin
				clk_cnt <= '0;
				if (bit_idx == uart_pkg::LAST_FRAME_BIT)
					busy <= 1'b0;	// stop bit done, line stays high
				else begin
					bit_idx <= bit_idx + 1'b1;
					tx_line <= shift_reg[0];
				end
			end else
				clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// stop bits ride along at the top, ones shift in behind them
	always_ff @(posedge sys_clk) begin
		if (load)
			shift_reg <= {{uart_pkg::STOP_BITS{1'b1}}, tx_data};
		else if (bit_end)
			shift_reg <= {1'b1, shift_reg[uart_pkg::FRAME_BITS-2:1]};
	end

endmodule

// File: tb/uart_echo_tb.sv
// testbench for the uart line echo top level
// serial driver, serial monitor, assertions, watchdog
// tests: single byte, random line, bad stop bit, overflow, busy drop
`timescale 1ns/10ps

module uart_echo_tb;

	localparam int CHAR_CLKS = uart_pkg::FRAME_BITS * uart_pkg::CLKS_PER_BIT;
	// characters on the line per test, sent plus echoed
	localparam int TEST_CHARS = (1 + 5) + (5 + 9) + (3 + 6) + (62 + 64) + (3 + 6) + (1 + 5);
	localparam int LINE_COUNT = 6;
	localparam int WATCHDOG_CLKS =
		2 * (TEST_CHARS * CHAR_CLKS + LINE_COUNT * (echo_pkg::IDLE_GAP_CLKS + CHAR_CLKS));

	logic sys_clk;
	logic sys_rst_n;
	logic uart_rx_line;
	logic uart_tx_line;
	logic [echo_pkg::LEN_WIDTH-1:0] line_len;
	logic echo_busy;

	int seed;
	int busy_low_cnt;	// clocks since echo_busy last seen high, saturates
	logic [7:0] mon_q [$];	// bytes decoded from uart_tx_line

	uart_echo_top dut0 (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.uart_rx_line (uart_rx_line),
		.uart_tx_line (uart_tx_line),
		.line_len     (line_len),
		.echo_busy    (echo_busy)
	);

	always #50 sys_clk = ~sys_clk;

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped on error");
	endtask

	task automatic report_mismatch(input string name, input string what,
			input string exp_s, input string act_s);
		$display("mismatch %s %s: expected %s, actual %s", name, what, exp_s, act_s);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped on mismatch");
	endtask

	// the last marker is still on the line for one character after echo_busy drops
	always @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			busy_low_cnt <= CHAR_CLKS;
		else if (echo_busy)
			busy_low_cnt <= 0;
		else if (busy_low_cnt < CHAR_CLKS)
			busy_low_cnt <= busy_low_cnt + 1;
	end

	reset_state_chk: assert property (@(posedge sys_clk)
		$rose(sys_rst_n) |-> (uart_tx_line && !echo_busy && line_len == '0))
		else stop_with_error("outputs not in their idle state after reset");

	idle_line_chk: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(busy_low_cnt == CHAR_CLKS) |-> uart_tx_line)
		else stop_with_error("uart_tx_line went low while no echo was running");

	// printable, never the marker byte
	function automatic logic [7:0] rand_printable();
		logic [7:0] c;
		c = echo_pkg::FRAME_MARK;
		while (c == echo_pkg::FRAME_MARK)
			c = 8'(32'h21 + ($unsigned($random(seed)) % 32'd94));
		return c;
	endfunction

	// one 8N1 character, called and returning on a falling edge
	task automatic send_serial(input logic [7:0] data, input bit bad_stop);
		logic [uart_pkg::FRAME_BITS-1:0] frame;
		frame = {~bad_stop, data, 1'b0};
		for (int i = 0; i < uart_pkg::FRAME_BITS - 1; i++) begin
			uart_rx_line = frame[i];
			repeat (uart_pkg::CLKS_PER_BIT) @(negedge sys_clk);
		end
		uart_rx_line = frame[uart_pkg::FRAME_BITS-1];
		if (bad_stop) begin
			// bad stop stays low past the mid-bit sample
			repeat (uart_pkg::CLKS_PER_BIT * 3 / 4) @(negedge sys_clk);
			uart_rx_line = 1'b1;	// high again so the next start edge is seen
			repeat (uart_pkg::CLKS_PER_BIT / 4) @(negedge sys_clk);
		end else
			repeat (uart_pkg::CLKS_PER_BIT) @(negedge sys_clk);
	endtask

	task automatic send_line(input logic [7:0] bytes [$]);
		for (int i = 0; i < bytes.size(); i++)
			send_serial(bytes[i], 1'b0);
	endtask

	task automatic wait_busy_high();
		while (!echo_busy)
			@(negedge sys_clk);
	endtask

	// echo over once busy is low and the last character has left the line
	task automatic wait_echo_idle();
		while (echo_busy)
			@(negedge sys_clk);
		while (busy_low_cnt < CHAR_CLKS)
			@(negedge sys_clk);
	endtask

	task automatic check_echo(input string name, input logic [7:0] payload [$]);
		logic [7:0] exp_q [$];
		int n_pay;
		n_pay = (payload.size() > echo_pkg::MAX_PAYLOAD) ? echo_pkg::MAX_PAYLOAD
			: payload.size();
		for (int i = 0; i < echo_pkg::MARK_COUNT; i++)
			exp_q.push_back(echo_pkg::FRAME_MARK);
		for (int i = 0; i < n_pay; i++)
			exp_q.push_back(payload[i]);
		for (int i = 0; i < echo_pkg::MARK_COUNT; i++)
			exp_q.push_back(echo_pkg::FRAME_MARK);
		echo_size_chk: assert (mon_q.size() == exp_q.size())
			else report_mismatch(name, "echo length", $sformatf("%0d", exp_q.size()),
				$sformatf("%0d", mon_q.size()));
		for (int i = 0; i < exp_q.size(); i++) begin
			echo_byte_chk: assert (mon_q[i] == exp_q[i])
				else report_mismatch(name, $sformatf("byte %0d", i),
					$sformatf("%02h", exp_q[i]), $sformatf("%02h", mon_q[i]));
		end
		line_len_chk: assert (line_len == echo_pkg::LEN_WIDTH'(n_pay))
			else report_mismatch(name, "line_len", $sformatf("%0d", n_pay),
				$sformatf("%0d", line_len));
		mon_q.delete();
	endtask

	task automatic run_single_byte();
		logic [7:0] line_q [$];
		line_q.push_back(8'h41);	// "A"
		send_line(line_q);
		wait_busy_high();
		wait_echo_idle();
		check_echo("single_byte", line_q);
	endtask

	task automatic run_random_line();
		logic [7:0] line_q [$];
		for (int i = 0; i < 5; i++)
			line_q.push_back(rand_printable());
		send_line(line_q);
		wait_busy_high();
		wait_echo_idle();
		check_echo("random_line", line_q);
	endtask

	// middle byte has its stop bit forced low
	task automatic run_bad_stop();
		logic [7:0] good_q [$];
		logic [7:0] bad_byte;
		good_q.push_back(rand_printable());
		good_q.push_back(rand_printable());
		bad_byte = rand_printable();
		send_serial(good_q[0], 1'b0);
		send_serial(bad_byte, 1'b1);
		send_serial(good_q[1], 1'b0);
		wait_busy_high();
		wait_echo_idle();
		check_echo("bad_stop", good_q);
	endtask

	task automatic run_overflow();
		logic [7:0] line_q [$];
		for (int i = 0; i < echo_pkg::MAX_PAYLOAD + 2; i++)
			line_q.push_back(rand_printable());
		send_line(line_q);
		wait_busy_high();
		wait_echo_idle();
		check_echo("overflow", line_q);
	endtask

	task automatic run_busy_drop();
		logic [7:0] line_q [$];
		logic [7:0] next_q [$];
		line_q.push_back(8'h58);	// "X"
		line_q.push_back(8'h59);	// "Y"
		next_q.push_back(8'h51);	// "Q"
		send_line(line_q);
		wait_busy_high();
		send_serial(8'h5a, 1'b0);	// "Z", arrives mid echo
		busy_window_chk: assert (echo_busy)
			else stop_with_error("echo finished before the extra byte was received");
		wait_echo_idle();
		check_echo("busy_drop", line_q);
		send_line(next_q);
		wait_busy_high();
		wait_echo_idle();
		check_echo("after_busy", next_q);
	endtask

	initial begin : tx_monitor
		logic [7:0] rx_byte;
		forever begin
			@(negedge sys_clk);
			if (sys_rst_n === 1'b1 && uart_tx_line === 1'b0) begin
				repeat (uart_pkg::CLKS_PER_BIT / 2) @(negedge sys_clk);
				if (uart_tx_line === 1'b0) begin	// still low at mid start bit
					for (int b = 0; b < uart_pkg::DATA_BITS; b++) begin
						repeat (uart_pkg::CLKS_PER_BIT) @(negedge sys_clk);
						rx_byte[b] = uart_tx_line;
					end
					repeat (uart_pkg::CLKS_PER_BIT) @(negedge sys_clk);
					stop_bit_chk: assert (uart_tx_line === 1'b1)
						else stop_with_error("stop bit on uart_tx_line was low");
					mon_q.push_back(rx_byte);
				end
			end
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CLKS) @(posedge sys_clk);
		$display("run timed out after %0d clocks without finishing the tests", WATCHDOG_CLKS);
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		seed = 65720;
		sys_clk = 1'b0;
		sys_rst_n = 1'b0;
		uart_rx_line = 1'b1;
		repeat (2) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		repeat (2) @(negedge sys_clk);
		run_single_byte();
		run_random_line();
		run_bad_stop();
		run_overflow();
		run_busy_drop();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: uart_echo.f
hdl/uart_pkg.sv
hdl/echo_pkg.sv
hdl/uart_rx.sv
hdl/echo_line_buffer.sv
hdl/uart_tx.sv
hdl/uart_echo_top.sv
tb/uart_echo_tb.sv
